/* bench/state_cache_cases.txt */
# name op(0 lookup, 1 delete) word(hex) kind(0 lookup, 1 delete) error data(hex)
# Lookup data is {3'b0, new, id}, delete data is the key that owned the ID
new_key_a        0  10  0  0  10
hit_key_a        0  10  0  0  00
new_id1          0  21  0  0  11
new_id2          0  32  0  0  12
hit_key_b        0  21  0  0  01
new_id3          0  43  0  0  13
del_free_id12    1  0c  1  1  00
new_id4          0  54  0  0  14
new_id5          0  65  0  0  15
new_id6          0  76  0  0  16
new_id7          0  87  0  0  17
new_id8          0  98  0  0  18
new_id9          0  a9  0  0  19
new_id10         0  ba  0  0  1a
new_id11         0  cb  0  0  1b
new_id12         0  dc  0  0  1c
new_id13         0  ed  0  0  1d
new_id14         0  fe  0  0  1e
new_id15         0  0f  0  0  1f
full_miss        0  ab  0  1  00
full_hit         0  32  0  0  02
del_id5          1  05  1  0  65
del_id5_again    1  05  1  1  00
reuse_id5        0  ab  0  0  15
hit_reused       0  ab  0  0  05
del_id0          1  00  1  0  10
reuse_id0        0  c3  0  0  10
full_again       0  10  0  1  00
hit_key_last     0  0f  0  0  0f
del_high_bits    1  3f  1  0  0f

/* bench/tb_state_cache.sv */
`timescale 1ns/1ps

module tb_state_cache;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int HOLD_AT        = 6;
    localparam int HOLD_CYCLES    = 40;
    localparam int DRAIN_CYCLES   = 20;
    localparam     CASES_FILE     = "bench/state_cache_cases.txt";

    logic                  clk = 1'b0;
    logic                  htable_srst;
    logic                  i_req_valid;
    htable_pkg::op_t       i_req_op;
    logic [7:0]            i_req_word;
    logic                  o_req_credit;
    logic                  o_rsp_valid;
    htable_pkg::rsp_kind_t o_rsp_kind;
    logic                  o_rsp_error;
    htable_pkg::rsp_data_u o_rsp_data;
    logic                  i_rsp_credit;

    // Case table with one entry per line of the cases file
    string       case_name [$];
    int          case_op   [$];
    int          case_word [$];
    int          case_kind [$];
    int          case_err  [$];
    int          case_data [$];

    logic [16:0] lfsr = 17'd73451;
    int          num_cases;
    int          req_idx;
    int          rsp_idx;
    int          req_cred;
    int          rsp_bal;
    int          gap_left;
    int          hold_left;
    int          hold_seen;
    int          hold_bal;
    int          cycles;
    logic        hold_done;
    logic        give_credit;

    always #50 clk = ~clk;

    state_cache i_state_cache (
        .clk          ( clk ),
        .htable_srst  ( htable_srst ),
        .i_req_valid  ( i_req_valid ),
        .i_req_op     ( i_req_op ),
        .i_req_word   ( i_req_word ),
        .o_req_credit ( o_req_credit ),
        .o_rsp_valid  ( o_rsp_valid ),
        .o_rsp_kind   ( o_rsp_kind ),
        .o_rsp_error  ( o_rsp_error ),
        .o_rsp_data   ( o_rsp_data ),
        .i_rsp_credit ( i_rsp_credit )
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string name, input string field,
                                   input logic [7:0] exp, input logic [7:0] act);
        $display("FAILED %s %s: expected %02h, actual %02h", name, field, exp, act);
        $display("Result: FAILED");
        $fatal(1, "response mismatch");
    endtask

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    task automatic draw_bits(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    cnt;
        string line;
        string name;
        int    op;
        int    word;
        int    kind;
        int    err;
        int    data;
        fd = $fopen(CASES_FILE, "r");
        assert (fd != 0) else abort_run("Could not open the cases file");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) != "#") begin
                cnt = $sscanf(line, "%s %d %h %d %d %h", name, op, word, kind, err, data);
                if (cnt > 0) begin
                    assert (cnt == 6) else abort_run("Malformed line in the cases file");
                    case_name.push_back(name);
                    case_op.push_back(op);
                    case_word.push_back(word);
                    case_kind.push_back(kind);
                    case_err.push_back(err);
                    case_data.push_back(data);
                end
            end
        end
        $fclose(fd);
        num_cases = case_name.size();
        assert (num_cases > 0) else abort_run("The cases file holds no cases");
    endtask

    task automatic check_response(input int idx);
        logic [7:0] act_kind;
        logic [7:0] act_error;
        logic [7:0] act_data;
        act_kind  = {7'b0, o_rsp_kind};
        act_error = {7'b0, o_rsp_error};
        act_data  = o_rsp_data;
        assert (act_kind === 8'(case_kind[idx]))
            else report_mismatch(case_name[idx], "kind", 8'(case_kind[idx]), act_kind);
        assert (act_error === 8'(case_err[idx]))
            else report_mismatch(case_name[idx], "error", 8'(case_err[idx]), act_error);
        assert (act_data === 8'(case_data[idx]))
            else report_mismatch(case_name[idx], "data", 8'(case_data[idx]), act_data);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus and checking on the falling edge
    // ------------------------------------------------------------------------
    initial begin
        htable_srst  = 1'b1;
        i_req_valid  = 1'b0;
        i_req_op     = htable_pkg::OP_LOOKUP;
        i_req_word   = '0;
        i_rsp_credit = 1'b0;
        req_idx      = 0;
        rsp_idx      = 0;
        req_cred     = htable_pkg::REQ_DEPTH;
        rsp_bal      = htable_pkg::RSP_CREDITS;
        gap_left     = 0;
        hold_left    = 0;
        hold_seen    = 0;
        hold_bal     = 0;
        hold_done    = 1'b0;
        cycles       = 0;
        load_cases();

        repeat (4) @(posedge clk);
        @(negedge clk);
        htable_srst = 1'b0;

        while (rsp_idx < num_cases) begin
            @(negedge clk);
            cycles++;
            assert (cycles < TIMEOUT_CYCLES)
                else abort_run("Timeout: the DUT stopped returning responses");
            assert (!$isunknown(o_rsp_valid) && !$isunknown(o_req_credit))
                else abort_run("A DUT handshake output is unknown");

            if (o_rsp_valid) begin
                assert (rsp_bal > 0)
                    else abort_run("DUT sent a response without a response credit");
                assert (rsp_idx < req_idx)
                    else abort_run("DUT sent a response with no request outstanding");
                check_response(rsp_idx);
                rsp_idx++;
                if (hold_left > 0) hold_seen++;
            end

            // Withhold response credits once to force back-pressure
            if (rsp_idx == HOLD_AT && !hold_done) begin
                hold_done = 1'b1;
                hold_left = HOLD_CYCLES;
                hold_seen = 0;
                // Credits the DUT still holds once this response is sent
                hold_bal  = rsp_bal - int'(o_rsp_valid);
            end

            give_credit = 1'b0;
            if (hold_left > 0) begin
                hold_left--;
                if (hold_left == 0) begin
                    assert (hold_seen == hold_bal)
                        else abort_run("DUT did not use exactly its held response credits");
                end
            end else if (gap_left > 0) begin
                gap_left--;
            end else if (rsp_bal - int'(o_rsp_valid) < htable_pkg::RSP_CREDITS) begin
                give_credit = 1'b1;
                draw_bits(2, gap_left);
            end
            rsp_bal      = rsp_bal - int'(o_rsp_valid) + int'(give_credit);
            i_rsp_credit = give_credit;

            // Request side spends one credit per sent request
            if (o_req_credit) req_cred++;
            assert (req_cred <= htable_pkg::REQ_DEPTH)
                else abort_run("DUT returned more request credits than it took");
            if (req_idx < num_cases && req_cred > 0) begin
                i_req_valid = 1'b1;
                i_req_op    = htable_pkg::op_t'(case_op[req_idx]);
                i_req_word  = 8'(case_word[req_idx]);
                req_idx++;
                req_cred--;
            end else begin
                i_req_valid = 1'b0;
                i_req_op    = htable_pkg::OP_LOOKUP;
                i_req_word  = '0;
            end
        end

        // Drain window with no further responses
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            assert (o_rsp_valid !== 1'b1)
                else abort_run("DUT sent a response after the last case");
            if (o_req_credit) req_cred++;
            i_req_valid  = 1'b0;
            i_rsp_credit = 1'b0;
        end
        assert (req_cred == htable_pkg::REQ_DEPTH)
            else abort_run("DUT did not return all request credits");

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* hw/cache_ifs.sv */
`timescale 1ns/1ps

// ----------------------------------------------------------------------------
// Ingress to engine
// ----------------------------------------------------------------------------
interface cache_req_if;
    logic              valid;
    htable_pkg::op_t   op;
    htable_pkg::key_t  word;
    // Pops the head entry
    logic              take;

    modport src (output valid, output op, output word, input take);
    modport dst (input valid, input op, input word, output take);
endinterface

// ----------------------------------------------------------------------------
// Engine to egress
// ----------------------------------------------------------------------------
interface cache_rsp_if;
    logic                   push;
    htable_pkg::rsp_kind_t  kind;
    logic                   error;
    htable_pkg::rsp_data_u  data;
    // High while the response FIFO can take an entry
    logic                   space;

    modport src (output push, output kind, output error, output data, input space);
    modport dst (input push, input kind, input error, input data, output space);
endinterface

/* hw/htable_pkg.sv */
package htable_pkg;

    // ------------------------------------------------------------------------
    // Widths and depths
    // ------------------------------------------------------------------------
    localparam int KEY_W       = 8;
    localparam int ID_W        = 4;
    localparam int KEY_SPACE   = 2 ** KEY_W;
    localparam int NUM_IDS     = 2 ** ID_W;

    // Request FIFO depth doubles as the sender's initial credit count
    localparam int REQ_DEPTH   = 4;
    localparam int REQ_PTR_W   = $clog2(REQ_DEPTH);

    localparam int RSP_DEPTH   = 2;
    localparam int RSP_PTR_W   = $clog2(RSP_DEPTH);
    localparam int RSP_CREDITS = 2;
    localparam int RSP_CRED_W  = $clog2(RSP_CREDITS + 1);

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------
    typedef logic [KEY_W-1:0] key_t;
    typedef logic [ID_W-1:0]  id_t;

    typedef enum logic {
        OP_LOOKUP = 1'b0,
        OP_DELETE = 1'b1
    } op_t;

    typedef enum logic {
        RSP_LOOKUP = 1'b0,
        RSP_DELETE = 1'b1
    } rsp_kind_t;

    typedef struct packed {
        logic [2:0] pad;
        logic       is_new;
        id_t        id;
    } lookup_result_t;

    // One response word, decoded by the response kind
    typedef union packed {
        lookup_result_t lookup;
        key_t           key;
    } rsp_data_u;

endpackage

/* hw/id_allocator.sv */
`timescale 1ns/1ps

module id_allocator (
    input  logic              clk,
    input  logic              htable_srst,
    input  logic              i_alloc,
    output logic              o_avail,
    output htable_pkg::id_t   o_alloc_id,
    input  logic              i_free,
    input  htable_pkg::id_t   i_free_id,
    input  htable_pkg::id_t   i_query_id,
    output logic              o_query_busy
);

    // One bit per ID, set while allocated
    logic [htable_pkg::NUM_IDS-1:0] busy;

    always_ff @(posedge clk) begin
        if (htable_srst) begin
            busy <= '0;
        end else begin
            if (i_alloc && o_avail) busy[o_alloc_id] <= 1'b1;
            if (i_free) busy[i_free_id] <= 1'b0;
        end
    end

    // Lowest free ID wins
    always_comb begin
        o_alloc_id = '0;
        for (int i = htable_pkg::NUM_IDS - 1; i >= 0; i--) begin
            if (!busy[i]) o_alloc_id = htable_pkg::id_t'(i);
        end
    end

    assign o_avail      = ~&busy;
    assign o_query_busy = busy[i_query_id];

    // Engine checks ownership before it frees
    assert property (@(posedge clk) disable iff (htable_srst)
        i_free |-> busy[i_free_id])
        else $error("free of an ID that is not allocated");

endmodule

/* hw/key_store.sv */
`timescale 1ns/1ps

module key_store (
    input  logic               clk,
    input  logic               htable_srst,
    input  htable_pkg::key_t   i_rd_key,
    output logic               o_hit,
    output htable_pkg::id_t    o_hit_id,
    input  htable_pkg::id_t    i_rd_id,
    output htable_pkg::key_t   o_owner_key,
    input  logic               i_ins,
    input  htable_pkg::key_t   i_ins_key,
    input  htable_pkg::id_t    i_ins_id,
    input  logic               i_del,
    input  htable_pkg::key_t   i_del_key
);

    logic [htable_pkg::KEY_SPACE-1:0] kt_valid;
    htable_pkg::id_t                  kt_id   [htable_pkg::KEY_SPACE];
    // ID to key
    htable_pkg::key_t                 rev_map [htable_pkg::NUM_IDS];

    always_ff @(posedge clk) begin
        if (htable_srst) begin
            kt_valid <= '0;
        end else begin
            if (i_ins) kt_valid[i_ins_key] <= 1'b1;
            if (i_del) kt_valid[i_del_key] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_ins) begin
            kt_id[i_ins_key]  <= i_ins_id;
            rev_map[i_ins_id] <= i_ins_key;
        end
    end

    // Registered reads, data valid one cycle after the address
    always_ff @(posedge clk) begin
        o_hit       <= kt_valid[i_rd_key];
        o_hit_id    <= kt_id[i_rd_key];
        o_owner_key <= rev_map[i_rd_id];
    end

endmodule

/* hw/req_ingress.sv */
`timescale 1ns/1ps

module req_ingress (
    input  logic                  clk,
    input  logic                  htable_srst,
    input  logic                  i_valid,
    input  htable_pkg::op_t       i_op,
    input  logic [7:0]            i_word,
    output logic                  o_credit,
    cache_req_if.src              req
);

    htable_pkg::op_t                  op_mem   [htable_pkg::REQ_DEPTH];
    htable_pkg::key_t                 word_mem [htable_pkg::REQ_DEPTH];
    logic [htable_pkg::REQ_PTR_W-1:0] wr_ptr;
    logic [htable_pkg::REQ_PTR_W-1:0] rd_ptr;
    logic [htable_pkg::REQ_PTR_W:0]   count;

    // Storage
    always_ff @(posedge clk) begin
        if (i_valid) begin
            op_mem[wr_ptr]   <= i_op;
            word_mem[wr_ptr] <= i_word;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_valid) wr_ptr <= wr_ptr + 1'b1;
            if (req.take) rd_ptr <= rd_ptr + 1'b1;
            case ({i_valid, req.take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One credit back per popped entry
    always_ff @(posedge clk) begin
        if (htable_srst) o_credit <= 1'b0;
        else             o_credit <= req.take;
    end

    assign req.valid = (count != '0);
    assign req.op    = op_mem[rd_ptr];
    assign req.word  = word_mem[rd_ptr];

    // Sender must respect its credits
    assert property (@(posedge clk) disable iff (htable_srst)
        i_valid |-> (count < htable_pkg::REQ_DEPTH))
        else $error("request written into a full ingress FIFO");

endmodule

/* hw/rsp_egress.sv */
`timescale 1ns/1ps

module rsp_egress (
    input  logic                   clk,
    input  logic                   htable_srst,
    cache_rsp_if.dst               rsp,
    input  logic                   i_credit,
    output logic                   o_valid,
    output htable_pkg::rsp_kind_t  o_kind,
    output logic                   o_error,
    output htable_pkg::rsp_data_u  o_data
);

    htable_pkg::rsp_kind_t             kind_mem  [htable_pkg::RSP_DEPTH];
    logic                              error_mem [htable_pkg::RSP_DEPTH];
    htable_pkg::rsp_data_u             data_mem  [htable_pkg::RSP_DEPTH];
    logic [htable_pkg::RSP_PTR_W-1:0]  wr_ptr;
    logic [htable_pkg::RSP_PTR_W-1:0]  rd_ptr;
    logic [htable_pkg::RSP_PTR_W:0]    count;
    logic [htable_pkg::RSP_CRED_W-1:0] credits;

    always_ff @(posedge clk) begin
        if (rsp.push) begin
            kind_mem[wr_ptr]  <= rsp.kind;
            error_mem[wr_ptr] <= rsp.error;
            data_mem[wr_ptr]  <= rsp.data;
        end
    end

    always_ff @(posedge clk) begin
        if (htable_srst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= htable_pkg::RSP_CRED_W'(htable_pkg::RSP_CREDITS);
        end else begin
            if (rsp.push) wr_ptr <= wr_ptr + 1'b1;
            if (o_valid) rd_ptr <= rd_ptr + 1'b1;
            case ({rsp.push, o_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Receiver grants, each sent response spends one
            case ({i_credit, o_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign o_valid   = (count != '0) && (credits != '0);
    assign o_kind    = kind_mem[rd_ptr];
    assign o_error   = error_mem[rd_ptr];
    assign o_data    = data_mem[rd_ptr];
    assign rsp.space = (count < htable_pkg::RSP_DEPTH);

    assert property (@(posedge clk) disable iff (htable_srst)
        credits <= htable_pkg::RSP_CREDITS)
        else $error("receiver returned more credits than granted");

endmodule

/* hw/state_cache.sv */
`timescale 1ns/1ps

module state_cache (
    input  logic                   clk,
    input  logic                   htable_srst,
    // Request channel
    input  logic                   i_req_valid,
    input  htable_pkg::op_t        i_req_op,
    input  logic [7:0]             i_req_word,
    output logic                   o_req_credit,
    // Response channel
    output logic                   o_rsp_valid,
    output htable_pkg::rsp_kind_t  o_rsp_kind,
    output logic                   o_rsp_error,
    output htable_pkg::rsp_data_u  o_rsp_data,
    input  logic                   i_rsp_credit
);

    cache_req_if req_if ();
    cache_rsp_if rsp_if ();

    req_ingress i_req_ingress (
        .clk         ( clk ),
        .htable_srst ( htable_srst ),
        .i_valid     ( i_req_valid ),
        .i_op        ( i_req_op ),
        .i_word      ( i_req_word ),
        .o_credit    ( o_req_credit ),
        .req         ( req_if.src )
    );

    state_engine i_state_engine (
        .clk         ( clk ),
        .htable_srst ( htable_srst ),
        .req         ( req_if.dst ),
        .rsp         ( rsp_if.src )
    );

    rsp_egress i_rsp_egress (
        .clk         ( clk ),
        .htable_srst ( htable_srst ),
        .rsp         ( rsp_if.dst ),
        .i_credit    ( i_rsp_credit ),
        .o_valid     ( o_rsp_valid ),
        .o_kind      ( o_rsp_kind ),
        .o_error     ( o_rsp_error ),
        .o_data      ( o_rsp_data )
    );

endmodule

/* hw/state_engine.sv */
`timescale 1ns/1ps

module state_engine (
    input  logic       clk,
    input  logic       htable_srst,
    cache_req_if.dst   req,
    cache_rsp_if.src   rsp
);

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_READ    = 2'd1,
        ST_DECIDE  = 2'd2,
        ST_RESPOND = 2'd3
    } state_t;

    state_t                 state;
    logic                   push_q;

    // Current request
    htable_pkg::op_t        cur_op;
    htable_pkg::key_t       cur_word;
    htable_pkg::id_t        cur_id;

    // Allocator and key store
    logic                   avail;
    htable_pkg::id_t        alloc_id;
    logic                   query_busy;
    logic                   hit;
    htable_pkg::id_t        hit_id;
    htable_pkg::key_t       owner_key;
    logic                   do_ins;
    logic                   do_del;
    logic                   ins;
    logic                   del;

    // Response
    htable_pkg::rsp_kind_t  nxt_kind;
    logic                   nxt_error;
    htable_pkg::rsp_data_u  nxt_data;
    htable_pkg::rsp_kind_t  rsp_kind_q;
    logic                   rsp_error_q;
    htable_pkg::rsp_data_u  rsp_data_q;

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            state  <= ST_IDLE;
            push_q <= 1'b0;
        end else begin
            push_q <= 1'b0;
            case (state)
                ST_IDLE:    if (req.valid) state <= ST_READ;
                ST_READ:    state <= ST_DECIDE;
                ST_DECIDE:  state <= ST_RESPOND;
                ST_RESPOND: begin
                    if (rsp.space) begin
                        push_q <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end
                default:    state <= ST_IDLE;
            endcase
        end
    end

    assign req.take = (state == ST_IDLE) && req.valid;

    always_ff @(posedge clk) begin
        if (req.take) begin
            cur_op   <= req.op;
            cur_word <= req.word;
        end
    end

    // Delete requests carry the ID in the low bits
    assign cur_id = cur_word[htable_pkg::ID_W-1:0];

    // ------------------------------------------------------------------------
    // Decision
    // ------------------------------------------------------------------------
    always_comb begin
        nxt_kind  = htable_pkg::RSP_LOOKUP;
        nxt_error = 1'b0;
        nxt_data  = '0;
        do_ins    = 1'b0;
        do_del    = 1'b0;
        if (cur_op == htable_pkg::OP_DELETE) begin
            nxt_kind = htable_pkg::RSP_DELETE;
            if (query_busy) begin
                do_del       = 1'b1;
                nxt_data.key = owner_key;
            end else begin
                nxt_error = 1'b1;
            end
        end else if (hit) begin
            nxt_data.lookup.id = hit_id;
        end else if (avail) begin
            // Miss, auto-insert with the lowest free ID
            do_ins                 = 1'b1;
            nxt_data.lookup.is_new = 1'b1;
            nxt_data.lookup.id     = alloc_id;
        end else begin
            nxt_error = 1'b1;
        end
    end

    assign ins = (state == ST_DECIDE) && do_ins;
    assign del = (state == ST_DECIDE) && do_del;

    always_ff @(posedge clk) begin
        if (state == ST_DECIDE) begin
            rsp_kind_q  <= nxt_kind;
            rsp_error_q <= nxt_error;
            rsp_data_q  <= nxt_data;
        end
    end

    assign rsp.push  = push_q;
    assign rsp.kind  = rsp_kind_q;
    assign rsp.error = rsp_error_q;
    assign rsp.data  = rsp_data_q;

    // ------------------------------------------------------------------------
    // Submodules
    // ------------------------------------------------------------------------
    id_allocator i_id_allocator (
        .clk          ( clk ),
        .htable_srst  ( htable_srst ),
        .i_alloc      ( ins ),
        .o_avail      ( avail ),
        .o_alloc_id   ( alloc_id ),
        .i_free       ( del ),
        .i_free_id    ( cur_id ),
        .i_query_id   ( cur_id ),
        .o_query_busy ( query_busy )
    );

    key_store i_key_store (
        .clk          ( clk ),
        .htable_srst  ( htable_srst ),
        .i_rd_key     ( cur_word ),
        .o_hit        ( hit ),
        .o_hit_id     ( hit_id ),
        .i_rd_id      ( cur_id ),
        .o_owner_key  ( owner_key ),
        .i_ins        ( ins ),
        .i_ins_key    ( cur_word ),
        .i_ins_id     ( alloc_id ),
        .i_del        ( del ),
        .i_del_key    ( owner_key )
    );

    // Space seen in RESPOND must still hold when the push lands
    assert property (@(posedge clk) disable iff (htable_srst)
        rsp.push |-> rsp.space)
        else $error("response pushed without FIFO space");

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the state cache testbench with Verilator.
# The exit status is nonzero if the build fails or the testbench fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module tb_state_cache \
    -Mdir obj_dir -o sim_state_cache
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_state_cache
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0

/* vlog.f */
hw/htable_pkg.sv
hw/cache_ifs.sv
hw/req_ingress.sv
hw/id_allocator.sv
hw/key_store.sv
hw/state_engine.sv
hw/rsp_egress.sv
hw/state_cache.sv
bench/tb_state_cache.sv
